// File: hdl/fetch_pc_gen.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_pc_gen #(
  parameter fetch_pkg::pc_t RESET_PC = 32'h1c000000
) (
  input  wire                 aclk,
  input  wire                 rst_n,
  input  wire                 redirect_valid,
  input  wire fetch_pkg::pc_t redirect_pc,
  input  wire                 pred_valid,
  input  wire fetch_pkg::pc_t pred_pc,
  input  wire                 fetch_credit,
  input  wire                 imem_req_ready,
  output logic                imem_req_valid,
  output fetch_pkg::pc_t      imem_req_addr,
  output logic                req_fire,
  output fetch_pkg::pc_t      req_pc
);

  import fetch_pkg::*;

  pc_t fetch_pc;
  pc_t line_step;
  pc_t next_pc;

  // request whenever the return stage has room for another line
  assign imem_req_valid = fetch_credit;
  assign imem_req_addr  = fetch_pc;
  assign req_fire       = imem_req_valid && imem_req_ready;
  assign req_pc         = fetch_pc;

  // next aligned line
  assign line_step = {fetch_pc[31:4], 4'b0000} + 32'd16;

  // backend redirect beats predecode, which beats the line step
  always_comb begin
    if (redirect_valid) begin
      next_pc = redirect_pc;
    end else if (pred_valid) begin
      next_pc = pred_pc;
    end else if (req_fire) begin
      next_pc = line_step;
    end else begin
      next_pc = fetch_pc;
    end
  end

  always_ff @(posedge aclk) begin
    if (!rst_n) begin
      fetch_pc <= RESET_PC;
    end else begin
      fetch_pc <= next_pc;
    end
  end

  // a waiting request keeps its address until accepted or redirected
  a_req_hold: assert property (
    @(posedge aclk) disable iff (!rst_n)
    imem_req_valid && !imem_req_ready && !redirect_valid && !pred_valid
    |=> imem_req_valid && $stable(imem_req_addr)
  );

endmodule

`default_nettype wire

// File: hdl/fetch_pkg.sv
`default_nettype none

package fetch_pkg;

  // instruction address
  typedef logic [31:0] pc_t;

  localparam int FETCH_SLOTS = 4;

  // unconditional jumps
  localparam logic [5:0] OP_B  = 6'h14;
  localparam logic [5:0] OP_BL = 6'h15;

  // conditional branch opcode range
  localparam logic [5:0] OP_BR_FIRST = 6'h16;
  localparam logic [5:0] OP_BR_LAST  = 6'h1b;

  // one 32-bit word, read as jump or as conditional branch
  typedef union packed {
    struct packed {
      logic [5:0]  opcode;
      logic [15:0] offs_lo;
      logic [9:0]  offs_hi;
    } jump26;
    struct packed {
      logic [5:0]  opcode;
      logic [15:0] offs;
      logic [4:0]  rj;
      logic [4:0]  rd;
    } branch16;
  } instr_word_u;

  // aligned 16-byte line, slot 0 at the lowest address
  typedef logic [FETCH_SLOTS-1:0][31:0] fetch_line_t;

endpackage

`default_nettype wire

// File: hdl/fetch_return.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_return #(
  parameter int IB_DEPTH     = 16,
  parameter int MAX_INFLIGHT = 2
) (
  input  wire                                                 aclk,
  input  wire                                                 rst_n,
  input  wire                                                 redirect_valid,
  input  wire                                                 req_fire,
  input  wire fetch_pkg::pc_t                                 req_pc,
  input  wire                                                 imem_resp_valid,
  input  wire fetch_pkg::fetch_line_t                         imem_resp_data,
  input  wire [$clog2(IB_DEPTH):0]                            free_slots,
  output logic                                                fetch_credit,
  output logic                                                pred_valid,
  output fetch_pkg::pc_t                                      pred_pc,
  output logic [2:0]                                          push_count,
  output fetch_pkg::pc_t [fetch_pkg::FETCH_SLOTS-1:0]         push_pcs,
  output fetch_pkg::instr_word_u [fetch_pkg::FETCH_SLOTS-1:0] push_words
);

  import fetch_pkg::*;

  localparam int PTR_W = (MAX_INFLIGHT > 1) ? $clog2(MAX_INFLIGHT) : 1;
  localparam int CNT_W = $clog2(MAX_INFLIGHT + 1);

  pc_t                    inflight_pc [MAX_INFLIGHT];
  logic [PTR_W-1:0]       head;
  logic [PTR_W-1:0]       tail;
  logic [CNT_W-1:0]       inflight_cnt;
  logic [CNT_W-1:0]       inflight_next;
  logic [CNT_W-1:0]       stale_cnt;
  logic                   credit_armed;
  logic                   resp_live;
  pc_t                    head_pc;
  logic [1:0]             start;
  instr_word_u            slot_word [FETCH_SLOTS];
  pc_t                    slot_pc [FETCH_SLOTS];
  pc_t                    slot_target [FETCH_SLOTS];
  logic [FETCH_SLOTS-1:0] slot_taken;
  logic [FETCH_SLOTS-1:0] keep;
  logic                   cut;

  assign head_pc       = inflight_pc[head];
  assign start         = head_pc[3:2];
  assign resp_live     = imem_resp_valid && (stale_cnt == '0);
  assign inflight_next = inflight_cnt + CNT_W'(req_fire) - CNT_W'(imem_resp_valid);

  // every line in flight keeps 4 buffer slots reserved
  assign fetch_credit = credit_armed && (inflight_cnt < CNT_W'(MAX_INFLIGHT)) &&
                        (int'(free_slots) >= FETCH_SLOTS * (int'(inflight_cnt) + 1));

  // static prediction per slot
  always_comb begin
    for (int i = 0; i < FETCH_SLOTS; i++) begin
      slot_word[i] = imem_resp_data[i];
      slot_pc[i]   = {head_pc[31:4], 2'(i), 2'b00};
      slot_taken[i]  = 1'b0;
      slot_target[i] = slot_pc[i];
      if (slot_word[i].jump26.opcode == OP_B || slot_word[i].jump26.opcode == OP_BL) begin
        slot_taken[i]  = 1'b1;
        slot_target[i] = slot_pc[i] + {{4{slot_word[i].jump26.offs_hi[9]}},
                         slot_word[i].jump26.offs_hi, slot_word[i].jump26.offs_lo, 2'b00};
      end else if (slot_word[i].branch16.opcode >= OP_BR_FIRST &&
                   slot_word[i].branch16.opcode <= OP_BR_LAST &&
                   slot_word[i].branch16.offs[15]) begin
        // backward branches only
        slot_taken[i]  = 1'b1;
        slot_target[i] = slot_pc[i] + {{14{1'b1}}, slot_word[i].branch16.offs, 2'b00};
      end
    end
  end

  // keep slots from the entry point up to the first taken one
  always_comb begin
    cut     = 1'b0;
    keep    = '0;
    pred_pc = '0;
    for (int i = 0; i < FETCH_SLOTS; i++) begin
      if (!cut && i >= int'(start)) begin
        keep[i] = 1'b1;
        if (slot_taken[i]) begin
          cut     = 1'b1;
          pred_pc = slot_target[i];
        end
      end
    end
  end

  assign pred_valid = resp_live && cut;
  assign push_count = resp_live ? 3'($countones(keep)) : 3'd0;

  // pack kept slots down to entry 0
  always_comb begin
    for (int j = 0; j < FETCH_SLOTS; j++) begin
      push_pcs[j]   = slot_pc[2'(start + 2'(j))];
      push_words[j] = slot_word[2'(start + 2'(j))];
    end
  end

  always_ff @(posedge aclk) begin
    if (req_fire) begin
      inflight_pc[tail] <= req_pc;
    end
  end

  always_ff @(posedge aclk) begin
    if (!rst_n) begin
      head         <= '0;
      tail         <= '0;
      inflight_cnt <= '0;
      stale_cnt    <= '0;
      credit_armed <= 1'b0;
    end else begin
      credit_armed <= 1'b1;
      inflight_cnt <= inflight_next;
      if (req_fire) begin
        tail <= (tail == PTR_W'(MAX_INFLIGHT - 1)) ? '0 : tail + 1'b1;
      end
      if (imem_resp_valid) begin
        head <= (head == PTR_W'(MAX_INFLIGHT - 1)) ? '0 : head + 1'b1;
      end
      // whatever is still out after this edge is wrong path
      if (redirect_valid || pred_valid) begin
        stale_cnt <= inflight_next;
      end else if (imem_resp_valid && stale_cnt != '0) begin
        stale_cnt <= stale_cnt - 1'b1;
      end
    end
  end

  a_resp_expected: assert property (
    @(posedge aclk) disable iff (!rst_n) imem_resp_valid |-> inflight_cnt != '0
  );

  a_inflight_limit: assert property (
    @(posedge aclk) disable iff (!rst_n) inflight_cnt <= CNT_W'(MAX_INFLIGHT)
  );

endmodule

`default_nettype wire

// File: hdl/fetch_top.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_top #(
  parameter fetch_pkg::pc_t RESET_PC     = 32'h1c000000,
  parameter int             IB_DEPTH     = 16,
  parameter int             MAX_INFLIGHT = 2
) (
  input  wire                         aclk,
  input  wire                         rst_n,
  input  wire                         redirect_valid,
  input  wire fetch_pkg::pc_t         redirect_pc,
  output logic                        imem_req_valid,
  output fetch_pkg::pc_t              imem_req_addr,
  input  wire                         imem_req_ready,
  input  wire                         imem_resp_valid,
  input  wire fetch_pkg::fetch_line_t imem_resp_data,
  output logic                        instr0_valid,
  output fetch_pkg::pc_t              instr0_pc,
  output fetch_pkg::instr_word_u      instr0_word,
  output logic                        instr1_valid,
  output fetch_pkg::pc_t              instr1_pc,
  output fetch_pkg::instr_word_u      instr1_word,
  input  wire [1:0]                   pop_count
);

  import fetch_pkg::*;

  logic                             req_fire;
  pc_t                              req_pc;
  logic                             fetch_credit;
  logic                             pred_valid;
  pc_t                              pred_pc;
  logic [2:0]                       push_count;
  pc_t [FETCH_SLOTS-1:0]            push_pcs;
  instr_word_u [FETCH_SLOTS-1:0]    push_words;
  logic [$clog2(IB_DEPTH):0]        free_slots;

  fetch_pc_gen #(
    .RESET_PC (RESET_PC)
  ) u_pc_gen (
    .aclk           (aclk),
    .rst_n          (rst_n),
    .redirect_valid (redirect_valid),
    .redirect_pc    (redirect_pc),
    .pred_valid     (pred_valid),
    .pred_pc        (pred_pc),
    .fetch_credit   (fetch_credit),
    .imem_req_ready (imem_req_ready),
    .imem_req_valid (imem_req_valid),
    .imem_req_addr  (imem_req_addr),
    .req_fire       (req_fire),
    .req_pc         (req_pc)
  );

  fetch_return #(
    .IB_DEPTH     (IB_DEPTH),
    .MAX_INFLIGHT (MAX_INFLIGHT)
  ) u_return (
    .aclk            (aclk),
    .rst_n           (rst_n),
    .redirect_valid  (redirect_valid),
    .req_fire        (req_fire),
    .req_pc          (req_pc),
    .imem_resp_valid (imem_resp_valid),
    .imem_resp_data  (imem_resp_data),
    .free_slots      (free_slots),
    .fetch_credit    (fetch_credit),
    .pred_valid      (pred_valid),
    .pred_pc         (pred_pc),
    .push_count      (push_count),
    .push_pcs        (push_pcs),
    .push_words      (push_words)
  );

  // backend redirect empties the buffer
  instr_buffer #(
    .IB_DEPTH (IB_DEPTH)
  ) u_ibuf (
    .aclk         (aclk),
    .rst_n        (rst_n),
    .flush        (redirect_valid),
    .push_count   (push_count),
    .push_pcs     (push_pcs),
    .push_words   (push_words),
    .pop_count    (pop_count),
    .free_slots   (free_slots),
    .instr0_valid (instr0_valid),
    .instr0_pc    (instr0_pc),
    .instr0_word  (instr0_word),
    .instr1_valid (instr1_valid),
    .instr1_pc    (instr1_pc),
    .instr1_word  (instr1_word)
  );

endmodule

`default_nettype wire

// File: hdl/instr_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module instr_buffer #(
  parameter int IB_DEPTH = 16
) (
  input  wire                                                 aclk,
  input  wire                                                 rst_n,
  input  wire                                                 flush,
  input  wire [2:0]                                           push_count,
  input  wire fetch_pkg::pc_t [fetch_pkg::FETCH_SLOTS-1:0]         push_pcs,
  input  wire fetch_pkg::instr_word_u [fetch_pkg::FETCH_SLOTS-1:0] push_words,
  input  wire [1:0]                                           pop_count,
  output logic [$clog2(IB_DEPTH):0]                           free_slots,
  output logic                                                instr0_valid,
  output fetch_pkg::pc_t                                      instr0_pc,
  output fetch_pkg::instr_word_u                              instr0_word,
  output logic                                                instr1_valid,
  output fetch_pkg::pc_t                                      instr1_pc,
  output fetch_pkg::instr_word_u                              instr1_word
);

  import fetch_pkg::*;

  localparam int PTR_W = $clog2(IB_DEPTH);
  localparam int CNT_W = PTR_W + 1;

  pc_t              pc_mem [IB_DEPTH];
  instr_word_u      word_mem [IB_DEPTH];
  logic [PTR_W-1:0] rd_ptr;
  logic [PTR_W-1:0] rd_ptr_1;
  logic [PTR_W-1:0] wr_ptr;
  logic [CNT_W-1:0] count;

  assign rd_ptr_1   = rd_ptr + 1'b1;
  assign free_slots = CNT_W'(IB_DEPTH) - count;

  // two oldest entries face decode
  assign instr0_valid = count >= CNT_W'(1);
  assign instr1_valid = count >= CNT_W'(2);
  assign instr0_pc    = pc_mem[rd_ptr];
  assign instr0_word  = word_mem[rd_ptr];
  assign instr1_pc    = pc_mem[rd_ptr_1];
  assign instr1_word  = word_mem[rd_ptr_1];

  // up to four writes per edge, wrapping at the end
  always_ff @(posedge aclk) begin
    for (int j = 0; j < FETCH_SLOTS; j++) begin
      if (3'(j) < push_count) begin
        pc_mem[PTR_W'(wr_ptr + PTR_W'(j))]   <= push_pcs[j];
        word_mem[PTR_W'(wr_ptr + PTR_W'(j))] <= push_words[j];
      end
    end
  end

  always_ff @(posedge aclk) begin
    if (!rst_n) begin
      rd_ptr <= '0;
      wr_ptr <= '0;
      count  <= '0;
    end else if (flush) begin
      // flush drops this edge's push and pop too
      rd_ptr <= '0;
      wr_ptr <= '0;
      count  <= '0;
    end else begin
      wr_ptr <= wr_ptr + PTR_W'(push_count);
      rd_ptr <= rd_ptr + PTR_W'(pop_count);
      count  <= count + CNT_W'(push_count) - CNT_W'(pop_count);
    end
  end

  // credit in the return stage keeps pushes within free space
  a_no_overflow: assert property (
    @(posedge aclk) disable iff (!rst_n) CNT_W'(push_count) <= free_slots
  );

  a_pop_legal: assert property (
    @(posedge aclk) disable iff (!rst_n)
    pop_count <= 2'(instr0_valid) + 2'(instr1_valid)
  );

endmodule

`default_nettype wire

// File: run.sh
#!/bin/sh
# build and run the fetch front end testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --assert -j 0 --top-module tb_fetch_top -f src.f -o sim_tb
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/sim_tb > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "Result: FAILED" "$LOG"; then
  echo "simulation reported a failure"
  exit 1
fi

if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if ! grep -q "Result: PASSED" "$LOG"; then
  echo "simulation ended without a result"
  exit 1
fi

exit 0

// File: src.f
hdl/fetch_pkg.sv
hdl/fetch_pc_gen.sv
hdl/fetch_return.sv
hdl/instr_buffer.sv
hdl/fetch_top.sv
test/tb_fetch_top.sv

// File: test/tb_fetch_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_fetch_top;

  import fetch_pkg::*;

  localparam pc_t        RESET_PC   = 32'h1c000000;
  localparam int         ROWS       = 5;
  localparam logic [1:0] MODE_FULL  = 2'd0;
  localparam logic [1:0] MODE_RAND  = 2'd1;
  localparam logic [1:0] MODE_STALL = 2'd2;

  typedef struct packed {
    pc_t         start;
    pc_t         br0_addr;
    logic [31:0] br0_word;
    pc_t         br1_addr;
    logic [31:0] br1_word;
    logic [15:0] n_check;
    logic [1:0]  mode;
  } row_t;

  logic        aclk            = 1'b0;
  logic        rst_n           = 1'b0;
  logic        redirect_valid  = 1'b0;
  pc_t         redirect_pc     = '0;
  logic        imem_req_valid;
  pc_t         imem_req_addr;
  logic        imem_req_ready  = 1'b0;
  logic        imem_resp_valid = 1'b0;
  fetch_line_t imem_resp_data  = '0;
  logic        instr0_valid;
  pc_t         instr0_pc;
  instr_word_u instr0_word;
  logic        instr1_valid;
  pc_t         instr1_pc;
  instr_word_u instr1_word;
  logic [1:0]  pop_count       = 2'd0;

  row_t        rows [ROWS];
  logic [31:0] mem [pc_t];
  pc_t         acc_q [$];
  int          due_q [$];
  int          cyc             = 0;
  int          last_due        = -1;
  int          due;
  int          hold            = 0;
  bit          seen_req        = 1'b0;
  fetch_line_t line;
  bit          table_ready     = 1'b0;
  int          watchdog_cycles = 0;

  always #2 aclk = ~aclk;

  fetch_top #(
    .RESET_PC     (RESET_PC),
    .IB_DEPTH     (16),
    .MAX_INFLIGHT (2)
  ) dut (
    .aclk            (aclk),
    .rst_n           (rst_n),
    .redirect_valid  (redirect_valid),
    .redirect_pc     (redirect_pc),
    .imem_req_valid  (imem_req_valid),
    .imem_req_addr   (imem_req_addr),
    .imem_req_ready  (imem_req_ready),
    .imem_resp_valid (imem_resp_valid),
    .imem_resp_data  (imem_resp_data),
    .instr0_valid    (instr0_valid),
    .instr0_pc       (instr0_pc),
    .instr0_word     (instr0_word),
    .instr1_valid    (instr1_valid),
    .instr1_pc       (instr1_pc),
    .instr1_word     (instr1_word),
    .pop_count       (pop_count)
  );

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("Result: FAILED");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check_pc(input string name, input pc_t got, input pc_t exp);
    if (got !== exp)
      fail_run($sformatf("FAIL %s: got %h expected %h", name, got, exp));
  endtask

  task automatic check_word(input string name, input instr_word_u got, input instr_word_u exp);
    if (got !== exp)
      fail_run($sformatf("FAIL %s: got %h expected %h", name, got, exp));
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp)
      fail_run($sformatf("FAIL %s: got %h expected %h", name, got, exp));
  endtask

  task automatic check_outputs_idle();
    check_flag("imem_req_valid", imem_req_valid, 1'b0);
    check_flag("instr0_valid", instr0_valid, 1'b0);
    check_flag("instr1_valid", instr1_valid, 1'b0);
  endtask

  // filler never decodes as a jump or branch
  function automatic logic [31:0] mem_word(input pc_t addr);
    logic [31:0] w;
    if (!mem.exists(addr)) begin
      w = $urandom() ^ addr;
      while (w[31:26] >= 6'h14 && w[31:26] <= 6'h1b)
        w = $urandom() ^ addr;
      mem[addr] = w;
    end
    return mem[addr];
  endfunction

  function automatic logic [31:0] enc_jump(input logic [5:0] op, input int off);
    logic [25:0] o;
    o = off[25:0];
    return {op, o[15:0], o[25:16]};
  endfunction

  function automatic logic [31:0] enc_branch(input logic [5:0] op, input int off);
    return {op, off[15:0], 5'd3, 5'd7};
  endfunction

  // expected successor of pc in the predicted stream
  function automatic pc_t next_stream_pc(input pc_t pc);
    logic [31:0] w;
    int          off;
    w = mem_word(pc);
    if (w[31:26] == OP_B || w[31:26] == OP_BL) begin
      off = int'($signed({w[9:0], w[25:10]}));
      return pc + pc_t'(off * 4);
    end
    if (w[31:26] >= OP_BR_FIRST && w[31:26] <= OP_BR_LAST && w[25]) begin
      off = int'($signed(w[25:10]));
      return pc + pc_t'(off * 4);
    end
    return pc + 32'd4;
  endfunction

  // memory model with random ready stalls and in-order responses 1 to 4 cycles late
  always @(posedge aclk) begin
    cyc = cyc + 1;
    if (!rst_n) begin
      imem_req_ready  <= 1'b0;
      imem_resp_valid <= 1'b0;
    end else begin
      if (imem_req_valid && imem_req_ready) begin
        if (!seen_req) begin
          check_pc("imem_req_addr", imem_req_addr, RESET_PC);
          seen_req = 1'b1;
        end
        due = cyc + int'($urandom_range(1, 4)) - 1;
        if (due <= last_due)
          due = last_due + 1;
        last_due = due;
        acc_q.push_back(imem_req_addr);
        due_q.push_back(due);
        hold = int'($urandom_range(0, 2));
      end
      imem_req_ready <= (hold == 0);
      if (hold > 0)
        hold--;
      if (due_q.size() > 0 && due_q[0] <= cyc) begin
        for (int i = 0; i < FETCH_SLOTS; i++)
          line[i] = mem_word({acc_q[0][31:4], 4'b0000} + pc_t'(4 * i));
        imem_resp_data  <= line;
        imem_resp_valid <= 1'b1;
        void'(acc_q.pop_front());
        void'(due_q.pop_front());
      end else begin
        imem_resp_valid <= 1'b0;
      end
    end
  end

  initial begin
    wait (table_ready);
    repeat (watchdog_cycles) @(posedge aclk);
    fail_run($sformatf("watchdog expired after %0d cycles, stream stalled", watchdog_cycles));
  end

  initial begin
    pc_t         exp_pc;
    pc_t         got_pc;
    instr_word_u got_word;
    instr_word_u exp_word;
    string       pc_name;
    string       word_name;
    int          checked;
    int          p;
    int          p_prev;
    int          avail;
    int          stall_left;
    int          total;
    int          wait_cnt;

    void'($urandom(32'h52dc));
    // sequential, jumps, conditional branches, short run, back-pressure
    rows[0] = '{RESET_PC, 32'h0, 32'h0, 32'h0, 32'h0, 16'd24, MODE_FULL};
    rows[1] = '{32'h1c001008, 32'h1c00100c, enc_jump(OP_B, 32),
                32'h1c001094, enc_jump(OP_BL, -37), 16'd20, MODE_RAND};
    rows[2] = '{32'h1c002000, 32'h1c002004, enc_branch(6'h16, 16),
                32'h1c002014, enc_branch(6'h1b, -6), 16'd20, MODE_FULL};
    rows[3] = '{32'h1c003004, 32'h0, 32'h0, 32'h0, 32'h0, 16'd8, MODE_FULL};
    rows[4] = '{32'h1c004000, 32'h1c004018, enc_jump(OP_B, 256),
                32'h1c00441c, enc_branch(6'h18, -2), 16'd40, MODE_STALL};
    total = 0;
    for (int r = 0; r < ROWS; r++) begin
      if (rows[r].br0_word != 32'h0)
        mem[rows[r].br0_addr] = rows[r].br0_word;
      if (rows[r].br1_word != 32'h0)
        mem[rows[r].br1_addr] = rows[r].br1_word;
      total += int'(rows[r].n_check);
    end
    watchdog_cycles = total * 64 + 12;
    table_ready     = 1'b1;

    for (int i = 0; i < 10; i++) begin
      @(posedge aclk);
      if (i > 0)
        check_outputs_idle();
    end
    rst_n <= 1'b1;
    @(posedge aclk);
    check_outputs_idle();

    for (int r = 0; r < ROWS; r++) begin
      if (r > 0) begin
        // redirect on the edge that accepts a line, leaving it in flight
        wait_cnt = 0;
        do begin
          @(posedge aclk);
          wait_cnt++;
        end while (!(imem_req_valid && imem_req_ready) && wait_cnt < 16);
        redirect_valid <= 1'b1;
        redirect_pc    <= rows[r].start;
        @(posedge aclk);
        redirect_valid <= 1'b0;
      end
      exp_pc     = rows[r].start;
      checked    = 0;
      p_prev     = 0;
      stall_left = (rows[r].mode == MODE_STALL) ? 40 : 0;
      while (checked < int'(rows[r].n_check)) begin
        @(posedge aclk);
        for (int k = 0; k < p_prev; k++) begin
          if (k == 0) begin
            check_flag("instr0_valid", instr0_valid, 1'b1);
            pc_name   = "instr0_pc";
            word_name = "instr0_word";
            got_pc    = instr0_pc;
            got_word  = instr0_word;
          end else begin
            check_flag("instr1_valid", instr1_valid, 1'b1);
            pc_name   = "instr1_pc";
            word_name = "instr1_word";
            got_pc    = instr1_pc;
            got_word  = instr1_word;
          end
          exp_word = mem_word(exp_pc);
          check_pc(pc_name, got_pc, exp_pc);
          check_word(word_name, got_word, exp_word);
          exp_pc = next_stream_pc(exp_pc);
          checked++;
        end
        // next cycle holds at least what survives this pop
        avail = int'(instr0_valid) + int'(instr1_valid) - p_prev;
        if (avail < 0)
          avail = 0;
        if (stall_left > 0) begin
          stall_left--;
          p = 0;
        end else if (rows[r].mode == MODE_FULL) begin
          p = avail;
        end else begin
          p = int'($urandom_range(0, avail));
        end
        if (p > int'(rows[r].n_check) - checked)
          p = int'(rows[r].n_check) - checked;
        pop_count <= 2'(p);
        p_prev = p;
      end
    end
    $display("Result: PASSED");
    $finish;
  end

endmodule

`default_nettype wire
